// ==== flist.f ====
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/instruction_fetch.sv
hw/instruction_decode.sv
hw/execute_stage.sv
hw/data_access.sv
hw/pipeline.sv
testbench/pipeline_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pipeline_tb -f flist.f -o sim_pipeline \
	> build.log 2>&1 \
	&& ./obj_dir/sim_pipeline > sim.log 2>&1 \
	|| { echo "build or simulation failed"; exit 1; }

grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

// ==== testbench/pipeline_tb.sv ====
module pipeline_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk;
	logic reset;
	logic run;
	logic prog_we;
	logic [7:0] prog_addr;
	logic [31:0] prog_data;
	logic wb_en;
	logic [4:0] wb_addr;
	logic [31:0] wb_data;
	logic dmem_we;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;

	logic [31:0] prog [256];
	logic checking;

	// Expected architectural events, oldest first
	logic [31:0] exp_wb_addr [$];
	logic [31:0] exp_wb_data [$];
	logic [31:0] exp_st_addr [$];
	logic [31:0] exp_st_data [$];

	// Generator state: destinations of the two previous instructions
	int recent1;
	int recent2;
	int stored_addr [$];

	pipeline #(
		.data_width(32),
		.imem_depth_log2(8),
		.dmem_depth_log2(8)
	) dut (
		.clk(clk),
		.reset(reset),
		.run(run),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata)
	);

	always #2 clk = ~clk;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t: %s expected %h got %h", $time, name, exp, got);
			$display("TESTS FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////

	function automatic logic [31:0] enc_r(input mips_isa_pkg::funct_t fn, input int rs,
		input int rt, input int rd);
		return {mips_isa_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'h00, fn};
	endfunction

	function automatic logic [31:0] enc_i(input mips_isa_pkg::opcode_t op, input int rs,
		input int rt, input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	// Source register that the visibility rule allows
	function automatic int pick_src();
		int r;
		r = int'($urandom_range(0, 31));
		while (r != 0 && (r == recent1 || r == recent2)) begin
			r = int'($urandom_range(0, 31));
		end
		return r;
	endfunction

	function automatic void note_dest(input int d);
		recent2 = recent1;
		recent1 = d;
	endfunction

	// Any instruction except beq
	function automatic logic [31:0] gen_plain();
		mips_isa_pkg::funct_t fns [5];
		logic [31:0] w;
		int kind;
		int rs;
		int rt;
		int rd;
		int addr;
		fns = '{mips_isa_pkg::fn_add, mips_isa_pkg::fn_sub, mips_isa_pkg::fn_and,
			mips_isa_pkg::fn_or, mips_isa_pkg::fn_slt};
		kind = int'($urandom_range(0, 7));
		if (kind == 7 && stored_addr.size() == 0) begin
			kind = 5;
		end
		rs = pick_src();
		rt = pick_src();
		if (kind < 5) begin
			rd = int'($urandom_range(0, 31));
			w = enc_r(fns[kind], rs, rt, rd);
			note_dest(rd);
		end else if (kind == 5) begin
			rd = int'($urandom_range(1, 31));
			w = enc_i(mips_isa_pkg::op_addi, rs, rd, int'($urandom_range(0, 65535)));
			note_dest(rd);
		end else if (kind == 6) begin
			addr = 4 * int'($urandom_range(0, 63));
			stored_addr.push_back(addr);
			w = enc_i(mips_isa_pkg::op_sw, 0, rt, addr);
			note_dest(0);
		end else begin
			addr = stored_addr[$urandom_range(0, stored_addr.size() - 1)];
			rd = int'($urandom_range(1, 31));
			w = enc_i(mips_isa_pkg::op_lw, 0, rd, addr);
			note_dest(rd);
		end
		return w;
	endfunction

	function automatic int gen_random_program(input int size);
		int n;
		int rs;
		int rt;
		for (int i = 0; i < 256; i++) begin
			prog[i] = mips_isa_pkg::nop_instr;
		end
		recent1 = 0;
		recent2 = 0;
		stored_addr.delete();
		n = 0;
		while (n < size) begin
			if (n + 8 <= size && $urandom_range(0, 9) == 0) begin
				rs = pick_src();
				rt = ($urandom_range(0, 1) == 1) ? rs : pick_src();
				// Target lands among the four trailing nops or just past them
				prog[n] = enc_i(mips_isa_pkg::op_beq, rs, rt, 3 + int'($urandom_range(0, 4)));
				note_dest(0);
				n++;
				for (int k = 0; k < 3; k++) begin
					prog[n] = gen_plain();
					n++;
				end
				// On the taken path the delay slots are the direct predecessors
				n += 4;
			end else begin
				prog[n] = gen_plain();
				n++;
			end
		end
		return n;
	endfunction

	function automatic int load_directed_program();
		for (int i = 0; i < 256; i++) begin
			prog[i] = mips_isa_pkg::nop_instr;
		end
		prog[0] = enc_i(mips_isa_pkg::op_addi, 0, 1, 5);
		prog[1] = enc_i(mips_isa_pkg::op_addi, 0, 2, -3);
		prog[2] = enc_i(mips_isa_pkg::op_addi, 0, 3, 'h70);
		prog[4] = enc_r(mips_isa_pkg::fn_add, 1, 2, 4);
		prog[5] = enc_r(mips_isa_pkg::fn_sub, 1, 2, 5);
		prog[6] = enc_r(mips_isa_pkg::fn_and, 3, 1, 6);
		prog[7] = enc_r(mips_isa_pkg::fn_or, 3, 2, 7);
		prog[8] = enc_r(mips_isa_pkg::fn_slt, 2, 1, 8);
		prog[9] = enc_r(mips_isa_pkg::fn_slt, 1, 2, 9);
		// Write to r0 stays invisible
		prog[10] = enc_r(mips_isa_pkg::fn_add, 1, 1, 0);
		prog[11] = enc_i(mips_isa_pkg::op_sw, 0, 4, 'h10);
		prog[12] = enc_i(mips_isa_pkg::op_sw, 0, 5, 'h14);
		prog[14] = enc_i(mips_isa_pkg::op_lw, 0, 10, 'h10);
		prog[15] = enc_i(mips_isa_pkg::op_lw, 0, 11, 'h14);
		// Taken beq, 20 and 21 are skipped
		prog[16] = enc_i(mips_isa_pkg::op_beq, 1, 1, 5);
		prog[17] = enc_i(mips_isa_pkg::op_addi, 0, 12, 1);
		prog[18] = enc_i(mips_isa_pkg::op_addi, 0, 13, 2);
		prog[19] = enc_i(mips_isa_pkg::op_addi, 0, 14, 3);
		prog[20] = enc_i(mips_isa_pkg::op_addi, 0, 15, 99);
		prog[21] = enc_i(mips_isa_pkg::op_addi, 0, 15, 98);
		// Not taken
		prog[22] = enc_i(mips_isa_pkg::op_beq, 1, 2, 5);
		prog[23] = enc_i(mips_isa_pkg::op_addi, 0, 16, 7);
		prog[24] = enc_r(mips_isa_pkg::fn_sub, 4, 5, 19);
		prog[25] = enc_r(mips_isa_pkg::fn_or, 6, 7, 20);
		prog[26] = enc_i(mips_isa_pkg::op_addi, 0, 17, 44);
		prog[27] = enc_i(mips_isa_pkg::op_addi, 10, 18, 1);
		return 28;
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic void model_program(input int len);
		logic [31:0] regs [32];
		logic [31:0] mem [logic [31:0]];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] res;
		logic [4:0] rt;
		logic [4:0] rd;
		logic valid;
		int pc;
		int next;
		int slots;
		int redirect;
		for (int r = 0; r < 32; r++) begin
			regs[r] = '0;
		end
		pc = 0;
		slots = 0;
		redirect = -1;
		while (pc < len) begin
			w = prog[pc];
			a = regs[w[25:21]];
			b = regs[w[20:16]];
			rt = w[20:16];
			rd = w[15:11];
			simm = {{16{w[15]}}, w[15:0]};
			next = pc + 1;
			if (slots > 0) begin
				slots--;
				if (slots == 0 && redirect >= 0) begin
					next = redirect;
					redirect = -1;
				end
			end
			if (w[31:26] == mips_isa_pkg::op_rtype) begin
				valid = 1'b1;
				case (w[5:0])
					mips_isa_pkg::fn_add: res = a + b;
					mips_isa_pkg::fn_sub: res = a - b;
					mips_isa_pkg::fn_and: res = a & b;
					mips_isa_pkg::fn_or: res = a | b;
					mips_isa_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: valid = 1'b0;
				endcase
				if (valid && rd != 0) begin
					regs[rd] = res;
					exp_wb_addr.push_back(32'(rd));
					exp_wb_data.push_back(res);
				end
			end else if (w[31:26] == mips_isa_pkg::op_addi || w[31:26] == mips_isa_pkg::op_lw) begin
				res = a + simm;
				if (w[31:26] == mips_isa_pkg::op_lw) begin
					res = mem.exists(res) ? mem[res] : 32'h0;
				end
				if (rt != 0) begin
					regs[rt] = res;
					exp_wb_addr.push_back(32'(rt));
					exp_wb_data.push_back(res);
				end
			end else if (w[31:26] == mips_isa_pkg::op_sw) begin
				mem[a + simm] = b;
				exp_st_addr.push_back(a + simm);
				exp_st_data.push_back(b);
			end else if (w[31:26] == mips_isa_pkg::op_beq) begin
				slots = 3;
				if (a == b) begin
					redirect = pc + 1 + int'($signed(simm));
				end
			end
			pc = next;
		end
	endfunction

	// Compare every observed write with the model, in order
	always @(negedge clk) begin
		if (checking && wb_en) begin
			if (exp_wb_data.size() == 0) begin
				$display("A register write to r%0d came at %0t with none expected", wb_addr, $time);
				$display("TESTS FAILED");
				$fatal(1, "unexpected register write");
			end else begin
				check("wb_addr", 32'(wb_addr), exp_wb_addr.pop_front());
				check("wb_data", wb_data, exp_wb_data.pop_front());
			end
		end
		if (checking && dmem_we) begin
			if (exp_st_data.size() == 0) begin
				$display("A store to %h came at %0t with none expected", dmem_addr, $time);
				$display("TESTS FAILED");
				$fatal(1, "unexpected store");
			end else begin
				check("dmem_addr", dmem_addr, exp_st_addr.pop_front());
				check("dmem_wdata", dmem_wdata, exp_st_data.pop_front());
			end
		end
	end

	task automatic run_program(input int len);
		int cycles;
		reset = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		checking = 1'b0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		// Parked core stays silent
		repeat (20) begin
			@(negedge clk);
			check("wb_en", 32'(wb_en), 32'h0);
			check("dmem_we", 32'(dmem_we), 32'h0);
		end
		for (int i = 0; i < 256; i++) begin
			prog_we = 1'b1;
			prog_addr = 8'(i);
			prog_data = prog[i];
			@(negedge clk);
		end
		prog_we = 1'b0;
		model_program(len);
		checking = 1'b1;
		run = 1'b1;
		cycles = 0;
		while (exp_wb_data.size() != 0 || exp_st_data.size() != 0) begin
			@(negedge clk);
			cycles++;
			if (cycles > 1000) begin
				$display("Timeout: the expected register writes or stores never all came");
				$display("TESTS FAILED");
				$fatal(1, "timeout");
			end
		end
		// Instructions still in flight must not write anything extra
		repeat (8) @(negedge clk);
		checking = 1'b0;
		run = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		checking = 1'b0;
		void'($urandom(32'h0c8ce849));
		run_program(load_directed_program());
		run_program(gen_random_program(200));
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== hw/pipeline.sv ====
module pipeline #(
	parameter int data_width = 32,
	parameter int imem_depth_log2 = 8,
	parameter int dmem_depth_log2 = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic prog_we,
	input  logic [imem_depth_log2-1:0] prog_addr,
	input  logic [31:0] prog_data,
	output logic wb_en,
	output mips_isa_pkg::reg_addr_t wb_addr,
	output logic [data_width-1:0] wb_data,
	output logic dmem_we,
	output logic [data_width-1:0] dmem_addr,
	output logic [data_width-1:0] dmem_wdata
);

	// IF/ID
	logic [data_width-1:0] if_pc_plus4;
	logic [31:0] if_instruction;

	// ID/EX
	logic id_reg_write;
	logic id_mem_to_reg;
	logic id_branch;
	logic id_mem_read;
	logic id_mem_write;
	logic id_reg_dst;
	logic id_alu_src;
	mips_ctrl_pkg::alu_class_t id_alu_class;
	logic [data_width-1:0] id_pc_next;
	logic [data_width-1:0] id_rs_data;
	logic [data_width-1:0] id_rt_data;
	logic [data_width-1:0] id_imm;
	mips_isa_pkg::reg_addr_t id_rt;
	mips_isa_pkg::reg_addr_t id_rd;

	// EX/MEM
	logic [data_width-1:0] ex_branch_target;
	logic [data_width-1:0] ex_alu_result;
	logic [data_width-1:0] ex_store_data;
	logic ex_zero;
	mips_isa_pkg::reg_addr_t ex_dest;
	logic ex_reg_write;
	logic ex_mem_to_reg;
	logic ex_branch;
	logic ex_mem_read;
	logic ex_mem_write;

	// MEM/WB and the branch path back to fetch
	logic mem_pc_src;
	logic [data_width-1:0] mem_branch_target;
	logic [data_width-1:0] mem_read_data;
	logic [data_width-1:0] mem_alu_result;
	mips_isa_pkg::reg_addr_t mem_dest;
	logic mem_reg_write;
	logic mem_mem_to_reg;

	instruction_fetch #(
		.data_width(data_width),
		.imem_depth_log2(imem_depth_log2)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.run(run),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.pc_src(mem_pc_src),
		.branch_target(mem_branch_target),
		.pc_plus4(if_pc_plus4),
		.instruction(if_instruction)
	);

	instruction_decode #(
		.data_width(data_width)
	) u_decode (
		.clk(clk),
		.reset(reset),
		.instruction(if_instruction),
		.pc_plus4(if_pc_plus4),
		.wb_reg_write(mem_reg_write),
		.wb_mem_to_reg(mem_mem_to_reg),
		.wb_dest(mem_dest),
		.wb_read_data(mem_read_data),
		.wb_alu_result(mem_alu_result),
		.reg_write(id_reg_write),
		.mem_to_reg(id_mem_to_reg),
		.branch(id_branch),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.reg_dst(id_reg_dst),
		.alu_src(id_alu_src),
		.alu_class(id_alu_class),
		.pc_next(id_pc_next),
		.rs_data(id_rs_data),
		.rt_data(id_rt_data),
		.imm(id_imm),
		.rt(id_rt),
		.rd(id_rd),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	execute_stage #(
		.data_width(data_width)
	) u_execute (
		.clk(clk),
		.reset(reset),
		.reg_write(id_reg_write),
		.mem_to_reg(id_mem_to_reg),
		.branch(id_branch),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.reg_dst(id_reg_dst),
		.alu_src(id_alu_src),
		.alu_class(id_alu_class),
		.pc_next(id_pc_next),
		.rs_data(id_rs_data),
		.rt_data(id_rt_data),
		.imm(id_imm),
		.rt(id_rt),
		.rd(id_rd),
		.branch_target(ex_branch_target),
		.alu_result(ex_alu_result),
		.store_data(ex_store_data),
		.zero(ex_zero),
		.dest(ex_dest),
		.reg_write_out(ex_reg_write),
		.mem_to_reg_out(ex_mem_to_reg),
		.branch_out(ex_branch),
		.mem_read_out(ex_mem_read),
		.mem_write_out(ex_mem_write)
	);

	data_access #(
		.data_width(data_width),
		.dmem_depth_log2(dmem_depth_log2)
	) u_data_access (
		.clk(clk),
		.reset(reset),
		.branch_target(ex_branch_target),
		.zero(ex_zero),
		.alu_result(ex_alu_result),
		.store_data(ex_store_data),
		.dest(ex_dest),
		.reg_write(ex_reg_write),
		.mem_to_reg(ex_mem_to_reg),
		.branch(ex_branch),
		.mem_read(ex_mem_read),
		.mem_write(ex_mem_write),
		.pc_src(mem_pc_src),
		.branch_target_out(mem_branch_target),
		.read_data(mem_read_data),
		.alu_result_out(mem_alu_result),
		.dest_out(mem_dest),
		.reg_write_out(mem_reg_write),
		.mem_to_reg_out(mem_mem_to_reg),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata)
	);

endmodule

// ==== hw/data_access.sv ====
module data_access #(
	parameter int data_width = 32,
	parameter int dmem_depth_log2 = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic [data_width-1:0] branch_target,
	input  logic zero,
	input  logic [data_width-1:0] alu_result,
	input  logic [data_width-1:0] store_data,
	input  mips_isa_pkg::reg_addr_t dest,
	input  logic reg_write,
	input  logic mem_to_reg,
	input  logic branch,
	input  logic mem_read,
	input  logic mem_write,
	output logic pc_src,
	output logic [data_width-1:0] branch_target_out,
	output logic [data_width-1:0] read_data,
	output logic [data_width-1:0] alu_result_out,
	output mips_isa_pkg::reg_addr_t dest_out,
	output logic reg_write_out,
	output logic mem_to_reg_out,
	output logic dmem_we,
	output logic [data_width-1:0] dmem_addr,
	output logic [data_width-1:0] dmem_wdata
);

	logic [data_width-1:0] dmem [2**dmem_depth_log2];
	logic [dmem_depth_log2-1:0] word_index;

	assign word_index = alu_result[dmem_depth_log2+1:2];

	// Branch decision goes straight back to fetch
	assign pc_src = branch && zero;
	assign branch_target_out = branch_target;

	// Store seen this cycle
	assign dmem_we = mem_write;
	assign dmem_addr = alu_result;
	assign dmem_wdata = store_data;

	always_ff @(posedge clk) begin
		if (mem_write) begin
			dmem[word_index] <= store_data;
		end
	end

	////////////////////////////////////////
	// MEM/WB register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write_out <= 1'b0;
			mem_to_reg_out <= 1'b0;
		end else begin
			reg_write_out <= reg_write;
			mem_to_reg_out <= mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_read) begin
			read_data <= dmem[word_index];
		end
		alu_result_out <= alu_result;
		dest_out <= dest;
	end

	// A taken branch came from a beq, never from a store or ALU op
	a_pc_src_from_branch: assert property (
		@(posedge clk) disable iff (reset)
		pc_src |-> branch && !mem_write && !reg_write
	);

endmodule

// ==== hw/execute_stage.sv ====
module execute_stage #(
	parameter int data_width = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic reg_write,
	input  logic mem_to_reg,
	input  logic branch,
	input  logic mem_read,
	input  logic mem_write,
	input  logic reg_dst,
	input  logic alu_src,
	input  mips_ctrl_pkg::alu_class_t alu_class,
	input  logic [data_width-1:0] pc_next,
	input  logic [data_width-1:0] rs_data,
	input  logic [data_width-1:0] rt_data,
	input  logic [data_width-1:0] imm,
	input  mips_isa_pkg::reg_addr_t rt,
	input  mips_isa_pkg::reg_addr_t rd,
	output logic [data_width-1:0] branch_target,
	output logic [data_width-1:0] alu_result,
	output logic [data_width-1:0] store_data,
	output logic zero,
	output mips_isa_pkg::reg_addr_t dest,
	output logic reg_write_out,
	output logic mem_to_reg_out,
	output logic branch_out,
	output logic mem_read_out,
	output logic mem_write_out
);

	mips_isa_pkg::funct_t funct;
	mips_ctrl_pkg::alu_op_t alu_op;
	logic funct_legal;
	logic [data_width-1:0] operand_b;
	logic [data_width-1:0] result;

	// Low immediate bits carry the function field
	assign funct = mips_isa_pkg::funct_t'(imm[mips_isa_pkg::funct_msb:mips_isa_pkg::funct_lsb]);

	// ALU control
	always_comb begin
		funct_legal = 1'b1;
		alu_op = mips_ctrl_pkg::alu_add;
		case (alu_class)
			mips_ctrl_pkg::alu_class_sub: alu_op = mips_ctrl_pkg::alu_sub;
			mips_ctrl_pkg::alu_class_funct: begin
				case (funct)
					mips_isa_pkg::fn_add: alu_op = mips_ctrl_pkg::alu_add;
					mips_isa_pkg::fn_sub: alu_op = mips_ctrl_pkg::alu_sub;
					mips_isa_pkg::fn_and: alu_op = mips_ctrl_pkg::alu_and;
					mips_isa_pkg::fn_or: alu_op = mips_ctrl_pkg::alu_or;
					mips_isa_pkg::fn_slt: alu_op = mips_ctrl_pkg::alu_slt;
					default: funct_legal = 1'b0;
				endcase
			end
			default: alu_op = mips_ctrl_pkg::alu_add;
		endcase
	end

	assign operand_b = alu_src ? imm : rt_data;

	always_comb begin
		case (alu_op)
			mips_ctrl_pkg::alu_sub: result = rs_data - operand_b;
			mips_ctrl_pkg::alu_and: result = rs_data & operand_b;
			mips_ctrl_pkg::alu_or: result = rs_data | operand_b;
			mips_ctrl_pkg::alu_slt: result = {{(data_width-1){1'b0}},
				$signed(rs_data) < $signed(operand_b)};
			default: result = rs_data + operand_b;
		endcase
	end

	////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write_out <= 1'b0;
			mem_to_reg_out <= 1'b0;
			branch_out <= 1'b0;
			mem_read_out <= 1'b0;
			mem_write_out <= 1'b0;
		end else begin
			reg_write_out <= reg_write;
			mem_to_reg_out <= mem_to_reg;
			branch_out <= branch;
			mem_read_out <= mem_read;
			mem_write_out <= mem_write;
		end
	end

	always_ff @(posedge clk) begin
		// Word offset relative to the delay-slot PC
		branch_target <= pc_next + (imm << 2);
		alu_result <= result;
		zero <= (result == '0);
		store_data <= rt_data;
		dest <= reg_dst ? rd : rt;
	end

	// Decode only lets supported R-type functions through
	a_funct_legal: assert property (
		@(posedge clk) disable iff (reset)
		(alu_class == mips_ctrl_pkg::alu_class_funct) |-> funct_legal
	);

endmodule

// ==== hw/instruction_decode.sv ====
module instruction_decode #(
	parameter int data_width = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic [31:0] instruction,
	input  logic [data_width-1:0] pc_plus4,
	input  logic wb_reg_write,
	input  logic wb_mem_to_reg,
	input  mips_isa_pkg::reg_addr_t wb_dest,
	input  logic [data_width-1:0] wb_read_data,
	input  logic [data_width-1:0] wb_alu_result,
	output logic reg_write,
	output logic mem_to_reg,
	output logic branch,
	output logic mem_read,
	output logic mem_write,
	output logic reg_dst,
	output logic alu_src,
	output mips_ctrl_pkg::alu_class_t alu_class,
	output logic [data_width-1:0] pc_next,
	output logic [data_width-1:0] rs_data,
	output logic [data_width-1:0] rt_data,
	output logic [data_width-1:0] imm,
	output mips_isa_pkg::reg_addr_t rt,
	output mips_isa_pkg::reg_addr_t rd,
	output logic wb_en,
	output mips_isa_pkg::reg_addr_t wb_addr,
	output logic [data_width-1:0] wb_data
);

	mips_isa_pkg::opcode_t opcode;
	mips_isa_pkg::funct_t funct;
	mips_isa_pkg::reg_addr_t rs_addr;
	mips_isa_pkg::reg_addr_t rt_addr;
	mips_isa_pkg::reg_addr_t rd_addr;
	logic [data_width-1:0] imm_ext;
	logic [data_width-1:0] regs [32];
	logic [data_width-1:0] rs_val;
	logic [data_width-1:0] rt_val;

	logic funct_known;
	logic dec_reg_write;
	logic dec_mem_to_reg;
	logic dec_branch;
	logic dec_mem_read;
	logic dec_mem_write;
	logic dec_reg_dst;
	logic dec_alu_src;
	mips_ctrl_pkg::alu_class_t dec_alu_class;

	assign opcode = mips_isa_pkg::opcode_t'(
		instruction[mips_isa_pkg::op_msb:mips_isa_pkg::op_lsb]);
	assign funct = mips_isa_pkg::funct_t'(
		instruction[mips_isa_pkg::funct_msb:mips_isa_pkg::funct_lsb]);
	assign rs_addr = instruction[mips_isa_pkg::rs_msb:mips_isa_pkg::rs_lsb];
	assign rt_addr = instruction[mips_isa_pkg::rt_msb:mips_isa_pkg::rt_lsb];
	assign rd_addr = instruction[mips_isa_pkg::rd_msb:mips_isa_pkg::rd_lsb];
	assign imm_ext = {{(data_width-16){instruction[mips_isa_pkg::imm_msb]}},
		instruction[mips_isa_pkg::imm_msb:mips_isa_pkg::imm_lsb]};

	////////////////////////////////////////
	// Main control
	////////////////////////////////////////

	always_comb begin
		case (funct)
			mips_isa_pkg::fn_add, mips_isa_pkg::fn_sub, mips_isa_pkg::fn_and,
			mips_isa_pkg::fn_or, mips_isa_pkg::fn_slt: funct_known = 1'b1;
			default: funct_known = 1'b0;
		endcase
	end

	always_comb begin
		dec_reg_write = 1'b0;
		dec_mem_to_reg = 1'b0;
		dec_branch = 1'b0;
		dec_mem_read = 1'b0;
		dec_mem_write = 1'b0;
		dec_reg_dst = 1'b0;
		dec_alu_src = 1'b0;
		dec_alu_class = mips_ctrl_pkg::alu_class_add;
		case (opcode)
			// Unsupported functions, the all-zero nop included, become bubbles
			mips_isa_pkg::op_rtype: begin
				if (funct_known) begin
					dec_reg_write = 1'b1;
					dec_reg_dst = 1'b1;
					dec_alu_class = mips_ctrl_pkg::alu_class_funct;
				end
			end
			mips_isa_pkg::op_addi: begin
				dec_reg_write = 1'b1;
				dec_alu_src = 1'b1;
			end
			mips_isa_pkg::op_lw: begin
				dec_reg_write = 1'b1;
				dec_mem_to_reg = 1'b1;
				dec_mem_read = 1'b1;
				dec_alu_src = 1'b1;
			end
			mips_isa_pkg::op_sw: begin
				dec_mem_write = 1'b1;
				dec_alu_src = 1'b1;
			end
			mips_isa_pkg::op_beq: begin
				dec_branch = 1'b1;
				dec_alu_class = mips_ctrl_pkg::alu_class_sub;
			end
			// Unknown opcodes keep every control bit low
			default: begin
			end
		endcase
	end

	////////////////////////////////////////
	// Write-back select and register file
	////////////////////////////////////////

	assign wb_data = wb_mem_to_reg ? wb_read_data : wb_alu_result;
	assign wb_en = wb_reg_write && (wb_dest != '0);
	assign wb_addr = wb_dest;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// r0 reads zero, a same-cycle write is bypassed to the read
	always_comb begin
		if (rs_addr == '0) begin
			rs_val = '0;
		end else if (wb_en && (wb_dest == rs_addr)) begin
			rs_val = wb_data;
		end else begin
			rs_val = regs[rs_addr];
		end
		if (rt_addr == '0) begin
			rt_val = '0;
		end else if (wb_en && (wb_dest == rt_addr)) begin
			rt_val = wb_data;
		end else begin
			rt_val = regs[rt_addr];
		end
	end

	// ID/EX register
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_write <= 1'b0;
			mem_to_reg <= 1'b0;
			branch <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			reg_dst <= 1'b0;
			alu_src <= 1'b0;
			alu_class <= mips_ctrl_pkg::alu_class_add;
		end else begin
			reg_write <= dec_reg_write;
			mem_to_reg <= dec_mem_to_reg;
			branch <= dec_branch;
			mem_read <= dec_mem_read;
			mem_write <= dec_mem_write;
			reg_dst <= dec_reg_dst;
			alu_src <= dec_alu_src;
			alu_class <= dec_alu_class;
		end
	end

	always_ff @(posedge clk) begin
		pc_next <= pc_plus4;
		rs_data <= rs_val;
		rt_data <= rt_val;
		imm <= imm_ext;
		rt <= rt_addr;
		rd <= rd_addr;
	end

	a_unknown_op_is_bubble: assert property (
		@(posedge clk) disable iff (reset)
		!(opcode inside {mips_isa_pkg::op_rtype, mips_isa_pkg::op_addi, mips_isa_pkg::op_lw,
			mips_isa_pkg::op_sw, mips_isa_pkg::op_beq}) |=> !reg_write && !mem_write
	);

endmodule

// ==== hw/instruction_fetch.sv ====
module instruction_fetch #(
	parameter int data_width = 32,
	parameter int imem_depth_log2 = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic prog_we,
	input  logic [imem_depth_log2-1:0] prog_addr,
	input  logic [31:0] prog_data,
	input  logic pc_src,
	input  logic [data_width-1:0] branch_target,
	output logic [data_width-1:0] pc_plus4,
	output logic [31:0] instruction
);

	logic [31:0] imem [2**imem_depth_log2];
	logic [data_width-1:0] pc;
	logic [data_width-1:0] pc_inc;
	logic [data_width-1:0] pc_next;
	logic [imem_depth_log2-1:0] fetch_index;

	assign pc_inc = pc + data_width'(4);
	assign pc_next = pc_src ? branch_target : pc_inc;

	// Word index, byte offset dropped
	assign fetch_index = pc[imem_depth_log2+1:2];

	// Loader port, only while the core is parked
	always_ff @(posedge clk) begin
		if (prog_we && !run) begin
			imem[prog_addr] <= prog_data;
		end
	end

	////////////////////////////////////////
	// PC and IF/ID register
	////////////////////////////////////////

	// PC parks at 0 while run is low so fetch restarts there
	always_ff @(posedge clk) begin
		if (reset || !run) begin
			pc <= '0;
			instruction <= mips_isa_pkg::nop_instr;
		end else begin
			pc <= pc_next;
			instruction <= imem[fetch_index];
		end
	end

	always_ff @(posedge clk) begin
		pc_plus4 <= pc_inc;
	end

	// Loader and running core never share the memory
	a_no_load_while_running: assert property (
		@(posedge clk) disable iff (reset) !(prog_we && run)
	);

endmodule

// ==== hw/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

	// Coarse ALU request from the main control
	typedef enum logic [1:0] {
		// Address and immediate arithmetic
		alu_class_add   = 2'b00,
		// Equality compare for beq
		alu_class_sub   = 2'b01,
		// Operation taken from the function field
		alu_class_funct = 2'b10
	} alu_class_t;

	// Operation seen by the ALU itself
	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_sub = 3'b110,
		alu_slt = 3'b111
	} alu_op_t;

endpackage

// ==== hw/mips_isa_pkg.sv ====
package mips_isa_pkg;

	// Primary opcode in instruction bits 31:26
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_beq   = 6'h04,
		op_addi  = 6'h08,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// R-type function field in bits 5:0
	typedef enum logic [5:0] {
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_slt = 6'h2a
	} funct_t;

	typedef logic [4:0] reg_addr_t;

	// Instruction field positions
	localparam int op_msb    = 31;
	localparam int op_lsb    = 26;
	localparam int rs_msb    = 25;
	localparam int rs_lsb    = 21;
	localparam int rt_msb    = 20;
	localparam int rt_lsb    = 16;
	localparam int rd_msb    = 15;
	localparam int rd_lsb    = 11;
	localparam int imm_msb   = 15;
	localparam int imm_lsb   = 0;
	localparam int funct_msb = 5;
	localparam int funct_lsb = 0;

	// sll r0, r0, 0
	localparam logic [31:0] nop_instr = 32'h0000_0000;

endpackage
